/* verilog/stream_pkg.sv */
`default_nettype none

package stream_pkg;

    // converter side, one beat per sample clock group
    localparam int unsigned S_DATA_WIDTH = 128;

    // DMA side word
    localparam int unsigned M_DATA_WIDTH = 64;

    // lane layout inside a converter beat
    localparam int unsigned LANES = 8;
    localparam int unsigned LANE_WIDTH = 16;

    // unsigned sample sits in the low bits of its lane
    localparam int unsigned SAMPLE_WIDTH = 12;

    // output words per input beat
    localparam int unsigned WORDS_PER_BEAT = S_DATA_WIDTH / M_DATA_WIDTH;
    localparam int unsigned WORD_IDX_WIDTH = $clog2(WORDS_PER_BEAT);

endpackage

`default_nettype wire

/* verilog/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    // capture limits
    localparam int unsigned PRE_MAX = 16;
    localparam int unsigned POST_MAX = 64;
    localparam int unsigned FIFO_DEPTH = 128;

    // history holds PRE_MAX beats plus the trigger beat
    localparam int unsigned HIST_DEPTH = PRE_MAX + 1;

    localparam int unsigned TS_WIDTH = 32;
    localparam int unsigned FRAME_NO_WIDTH = 16;
    localparam int unsigned DROP_WIDTH = 16;
    localparam int unsigned PRE_LEN_WIDTH = 5;
    localparam int unsigned POST_LEN_WIDTH = 7;
    localparam int unsigned FRAME_LEN_WIDTH = 7;
    localparam int unsigned FREE_WIDTH = $clog2(FIFO_DEPTH + 1);

    // register map
    localparam logic [1:0] REG_THRESHOLD = 2'd0;
    localparam logic [1:0] REG_PRE_LEN = 2'd1;
    localparam logic [1:0] REG_POST_LEN = 2'd2;

    localparam logic [stream_pkg::SAMPLE_WIDTH-1:0] THRESHOLD_RST = 12'd2048;
    localparam logic [PRE_LEN_WIDTH-1:0] PRE_LEN_RST = 5'd4;
    localparam logic [POST_LEN_WIDTH-1:0] POST_LEN_RST = 7'd8;

    // header beat fields
    localparam logic [15:0] HDR_MAGIC = 16'hA5C0;
    localparam int unsigned HDR_TS_LSB = 0;
    localparam int unsigned HDR_FN_LSB = 32;
    localparam int unsigned HDR_MAGIC_LSB = 112;

    typedef struct packed {
        logic [stream_pkg::S_DATA_WIDTH-1:0] data;
        logic last;
    } frame_beat_t;

    function automatic logic [stream_pkg::S_DATA_WIDTH-1:0] build_header(
        input logic [TS_WIDTH-1:0] ts,
        input logic [FRAME_NO_WIDTH-1:0] frame_no
    );
        logic [stream_pkg::S_DATA_WIDTH-1:0] hdr;
        hdr = '0;
        hdr[HDR_TS_LSB +: TS_WIDTH] = ts;
        hdr[HDR_FN_LSB +: FRAME_NO_WIDTH] = frame_no;
        hdr[HDR_MAGIC_LSB +: 16] = HDR_MAGIC;
        return hdr;
    endfunction

endpackage

`default_nettype wire

/* verilog/capture_regs.sv */
`default_nettype none

module capture_regs (
    input wire AXIS_ACLK,
    input wire AXIS_ARESETN,
    input wire cfg_wr,
    input wire [1:0] cfg_addr,
    input wire [15:0] cfg_wdata,
    output logic [stream_pkg::SAMPLE_WIDTH-1:0] threshold,
    output logic [capture_pkg::PRE_LEN_WIDTH-1:0] pre_len,
    output logic [capture_pkg::POST_LEN_WIDTH-1:0] post_len
);
    import stream_pkg::*;
    import capture_pkg::*;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            threshold <= THRESHOLD_RST;
            pre_len <= PRE_LEN_RST;
            post_len <= POST_LEN_RST;
        end
        else if (cfg_wr)
        begin
            case (cfg_addr)
                REG_THRESHOLD:
                    threshold <= cfg_wdata[SAMPLE_WIDTH-1:0];
                // history deeper than PRE_MAX is not kept
                REG_PRE_LEN:
                    if (cfg_wdata > 16'(PRE_MAX))
                        pre_len <= PRE_LEN_WIDTH'(PRE_MAX);
                    else
                        pre_len <= cfg_wdata[PRE_LEN_WIDTH-1:0];
                // post section carries at least the trigger beat
                REG_POST_LEN:
                    if (cfg_wdata == 16'd0)
                        post_len <= POST_LEN_WIDTH'(1);
                    else if (cfg_wdata > 16'(POST_MAX))
                        post_len <= POST_LEN_WIDTH'(POST_MAX);
                    else
                        post_len <= cfg_wdata[POST_LEN_WIDTH-1:0];
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/level_trigger.sv */
`default_nettype none

module level_trigger (
    input wire AXIS_ACLK,
    input wire AXIS_ARESETN,
    input wire [stream_pkg::S_DATA_WIDTH-1:0] s_tdata,
    input wire s_tvalid,
    input wire [stream_pkg::SAMPLE_WIDTH-1:0] threshold,
    output logic trig,
    output logic [capture_pkg::TS_WIDTH-1:0] trig_ts
);
    import stream_pkg::*;
    import capture_pkg::*;

    logic over;
    logic prev_over;
    logic [TS_WIDTH-1:0] beat_cnt;

    // any lane at or above threshold
    always_comb
    begin
        over = 1'b0;
        for (int i = 0; i < LANES; i++)
        begin
            if (s_tdata[i*LANE_WIDTH +: SAMPLE_WIDTH] >= threshold)
                over = 1'b1;
        end
    end

    // fire on the first over-threshold beat only
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            trig <= 1'b0;
            prev_over <= 1'b0;
            beat_cnt <= '0;
        end
        else
        begin
            trig <= s_tvalid && over && !prev_over;
            if (s_tvalid)
            begin
                prev_over <= over;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (s_tvalid)
            trig_ts <= beat_cnt;
    end

endmodule

`default_nettype wire

/* verilog/capture_ctrl.sv */
`default_nettype none

module capture_ctrl (
    input wire AXIS_ACLK,
    input wire AXIS_ARESETN,
    input wire [stream_pkg::S_DATA_WIDTH-1:0] s_tdata,
    input wire s_tvalid,
    input wire trig,
    input wire [capture_pkg::TS_WIDTH-1:0] trig_ts,
    input wire [capture_pkg::PRE_LEN_WIDTH-1:0] pre_len,
    input wire [capture_pkg::POST_LEN_WIDTH-1:0] post_len,
    input wire [capture_pkg::FREE_WIDTH-1:0] fifo_free,
    output logic wr_en,
    output capture_pkg::frame_beat_t wr_data,
    output logic [capture_pkg::DROP_WIDTH-1:0] drop_count
);
    import stream_pkg::*;
    import capture_pkg::*;

    // hist[0] is the most recently accepted beat
    logic [S_DATA_WIDTH-1:0] hist [HIST_DEPTH];

    logic capturing;
    logic [PRE_LEN_WIDTH-1:0] pre_q;
    logic [FRAME_LEN_WIDTH-1:0] rem_q;
    logic [FRAME_NO_WIDTH-1:0] frame_no;
    logic data_vld;
    frame_beat_t data_q;

    logic busy;
    logic admit;
    logic drop;
    logic take;
    logic take_last;
    logic [FRAME_LEN_WIDTH-1:0] frame_len;
    logic [FRAME_LEN_WIDTH-1:0] rem_cur;
    logic [PRE_LEN_WIDTH-1:0] tap;
    logic [FREE_WIDTH-1:0] need;

    // pending data write still counts as busy so the header slot stays free
    assign busy = capturing || data_vld;

    // header plus pre and post sections must fit whole
    assign frame_len = FRAME_LEN_WIDTH'(pre_len) + FRAME_LEN_WIDTH'(post_len);
    assign need = FREE_WIDTH'(frame_len) + FREE_WIDTH'(1);
    assign admit = trig && !busy && (fifo_free >= need);
    assign drop = trig && !busy && (fifo_free < need);

    // lengths come live on the admit cycle, latched afterwards
    assign rem_cur = capturing ? rem_q : frame_len;
    assign tap = capturing ? pre_q : pre_len;

    // accepting beat X writes beat X-pre-1 one cycle later
    assign take = (capturing || admit) && s_tvalid;
    assign take_last = (rem_cur == FRAME_LEN_WIDTH'(1));

    assign wr_en = admit || data_vld;

    always_comb
    begin
        if (admit)
        begin
            wr_data.data = build_header(trig_ts, frame_no);
            wr_data.last = 1'b0;
        end
        else
        begin
            wr_data = data_q;
        end
    end

    // pre-trigger history, zero after reset
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            for (int i = 0; i < HIST_DEPTH; i++)
                hist[i] <= '0;
        end
        else if (s_tvalid)
        begin
            hist[0] <= s_tdata;
            for (int i = 1; i < HIST_DEPTH; i++)
                hist[i] <= hist[i-1];
        end
    end

    // frame sequencing and drop count
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            capturing <= 1'b0;
            pre_q <= '0;
            rem_q <= '0;
            frame_no <= '0;
            data_vld <= 1'b0;
            drop_count <= '0;
        end
        else
        begin
            data_vld <= take;
            if (admit)
            begin
                capturing <= 1'b1;
                pre_q <= pre_len;
                rem_q <= frame_len;
                frame_no <= frame_no + 1'b1;
            end
            if (drop)
                drop_count <= drop_count + 1'b1;
            if (take)
            begin
                rem_q <= rem_cur - 1'b1;
                if (take_last)
                    capturing <= 1'b0;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (take)
        begin
            data_q.data <= hist[tap];
            data_q.last <= take_last;
        end
    end

endmodule

`default_nettype wire

/* verilog/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int unsigned DEPTH = 16
) (
    input wire AXIS_ACLK,
    input wire AXIS_ARESETN,
    input wire wr_en,
    input wire payload_t wr_data,
    output logic rd_valid,
    input wire rd_ready,
    output payload_t rd_data,
    output logic [$clog2(DEPTH+1)-1:0] free,
    output logic full
);
    localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CW = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic do_wr;
    logic do_rd;

    assign full = (count == CW'(DEPTH));
    assign free = CW'(DEPTH) - count;
    assign do_wr = wr_en && !full;

    // head of queue shows on rd_data without a read request
    assign rd_valid = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* verilog/width_downsizer.sv */
`default_nettype none

module width_downsizer (
    input wire AXIS_ACLK,
    input wire AXIS_ARESETN,
    input wire rd_valid,
    output logic rd_ready,
    input wire capture_pkg::frame_beat_t rd_data,
    output logic [stream_pkg::M_DATA_WIDTH-1:0] m_tdata,
    output logic m_tvalid,
    input wire m_tready,
    output logic m_tuser,
    output logic m_tlast
);
    import stream_pkg::*;
    import capture_pkg::*;

    frame_beat_t beat_q;
    logic have_q;
    logic [WORD_IDX_WIDTH-1:0] word_q;
    logic hdr_q;
    // previous beat closed a frame, so the next one is a header
    logic frame_done_q;
    logic last_word;
    logic pop;

    assign last_word = (word_q == WORD_IDX_WIDTH'(WORDS_PER_BEAT - 1));

    // next beat only once every word of the held one is out
    assign rd_ready = !have_q || (last_word && m_tready);
    assign pop = rd_valid && rd_ready;

    // low half goes first
    assign m_tvalid = have_q;
    assign m_tdata = beat_q.data[word_q*M_DATA_WIDTH +: M_DATA_WIDTH];
    assign m_tuser = have_q && hdr_q && (word_q == '0);
    assign m_tlast = have_q && beat_q.last && last_word;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            have_q <= 1'b0;
            word_q <= '0;
            hdr_q <= 1'b0;
            frame_done_q <= 1'b1;
        end
        else if (pop)
        begin
            have_q <= 1'b1;
            word_q <= '0;
            hdr_q <= frame_done_q;
            frame_done_q <= rd_data.last;
        end
        else if (have_q && m_tready)
        begin
            if (last_word)
                have_q <= 1'b0;
            else
                word_q <= word_q + 1'b1;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (pop)
            beat_q <= rd_data;
    end

endmodule

`default_nettype wire

/* verilog/acq_top.sv */
`default_nettype none

module acq_top (
    input wire AXIS_ACLK,
    input wire AXIS_ARESETN,
    input wire [stream_pkg::S_DATA_WIDTH-1:0] s_tdata,
    input wire s_tvalid,
    output logic [stream_pkg::M_DATA_WIDTH-1:0] m_tdata,
    output logic m_tvalid,
    input wire m_tready,
    output logic m_tuser,
    output logic m_tlast,
    input wire cfg_wr,
    input wire [1:0] cfg_addr,
    input wire [15:0] cfg_wdata,
    output logic [capture_pkg::DROP_WIDTH-1:0] drop_count,
    output logic fifo_full
);
    import stream_pkg::*;
    import capture_pkg::*;

    logic [SAMPLE_WIDTH-1:0] threshold;
    logic [PRE_LEN_WIDTH-1:0] pre_len;
    logic [POST_LEN_WIDTH-1:0] post_len;
    logic trig;
    logic [TS_WIDTH-1:0] trig_ts;
    logic wr_en;
    frame_beat_t wr_data;
    logic rd_valid;
    logic rd_ready;
    frame_beat_t rd_data;
    logic [FREE_WIDTH-1:0] fifo_free;

    capture_regs regs0 (
        .AXIS_ACLK(AXIS_ACLK),
        .AXIS_ARESETN(AXIS_ARESETN),
        .cfg_wr(cfg_wr),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .threshold(threshold),
        .pre_len(pre_len),
        .post_len(post_len)
    );

    level_trigger trig0 (
        .AXIS_ACLK(AXIS_ACLK),
        .AXIS_ARESETN(AXIS_ARESETN),
        .s_tdata(s_tdata),
        .s_tvalid(s_tvalid),
        .threshold(threshold),
        .trig(trig),
        .trig_ts(trig_ts)
    );

    capture_ctrl ctrl0 (
        .AXIS_ACLK(AXIS_ACLK),
        .AXIS_ARESETN(AXIS_ARESETN),
        .s_tdata(s_tdata),
        .s_tvalid(s_tvalid),
        .trig(trig),
        .trig_ts(trig_ts),
        .pre_len(pre_len),
        .post_len(post_len),
        .fifo_free(fifo_free),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .drop_count(drop_count)
    );

    // frame beats queue for the DMA
    sync_fifo #(
        .payload_t(frame_beat_t),
        .DEPTH(FIFO_DEPTH)
    ) fifo0 (
        .AXIS_ACLK(AXIS_ACLK),
        .AXIS_ARESETN(AXIS_ARESETN),
        .wr_en(wr_en),
        .wr_data(wr_data),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready),
        .rd_data(rd_data),
        .free(fifo_free),
        .full(fifo_full)
    );

    width_downsizer dsz0 (
        .AXIS_ACLK(AXIS_ACLK),
        .AXIS_ARESETN(AXIS_ARESETN),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready),
        .rd_data(rd_data),
        .m_tdata(m_tdata),
        .m_tvalid(m_tvalid),
        .m_tready(m_tready),
        .m_tuser(m_tuser),
        .m_tlast(m_tlast)
    );

endmodule

`default_nettype wire

/* tests/acq_chk.sv */
`default_nettype none

module acq_chk (
    input wire AXIS_ACLK,
    input wire AXIS_ARESETN,
    input wire [stream_pkg::M_DATA_WIDTH-1:0] m_tdata,
    input wire m_tvalid,
    input wire m_tready,
    input wire m_tuser,
    input wire m_tlast,
    input wire wr_en,
    input wire full
);
    int unsigned fail_count = 0;

    // stalled word holds until the DMA takes it
    hold_while_stalled: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tuser)
            && $stable(m_tlast))
    else
    begin
        $error("output word changed while stalled");
        fail_count++;
    end

    no_write_when_full: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        !(wr_en && full))
    else
    begin
        $error("FIFO written while full");
        fail_count++;
    end

    idle_in_reset: assert property (@(posedge AXIS_ACLK) !AXIS_ARESETN |=> !m_tvalid)
    else
    begin
        $error("output valid during reset");
        fail_count++;
    end

endmodule

bind acq_top acq_chk chk0 (
    .AXIS_ACLK(AXIS_ACLK),
    .AXIS_ARESETN(AXIS_ARESETN),
    .m_tdata(m_tdata),
    .m_tvalid(m_tvalid),
    .m_tready(m_tready),
    .m_tuser(m_tuser),
    .m_tlast(m_tlast),
    .wr_en(wr_en),
    .full(fifo_full)
);

`default_nettype wire

/* tests/acq_tb.sv */
`default_nettype none

module acq_tb;
    import stream_pkg::*;
    import capture_pkg::*;

    localparam int NUM_TESTS = 6;
    localparam int MAX_SPIKES = 6;
    localparam int RESET_CYCLES = 8;
    localparam int ROW_OVERHEAD = 20;
    localparam int READY_HIGH = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_HELD_LOW = 2;
    localparam logic [31:0] LCG_SEED = 32'h9e97_7ae9;

    // one row per test with -1 in unused spike slots
    string name_tab [NUM_TESTS] = '{"default_single", "short_frame", "deep_history",
                                    "retrigger", "random_ready", "backpressure_drop"};
    bit cfg_tab [NUM_TESTS] = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    int thr_tab [NUM_TESTS] = '{2048, 1500, 3000, 1200, 2048, 2048};
    int pre_tab [NUM_TESTS] = '{4, 0, 16, 2, 4, 10};
    int post_tab [NUM_TESTS] = '{8, 3, 5, 6, 8, 32};
    int len_tab [NUM_TESTS] = '{60, 50, 40, 60, 100, 270};
    int mode_tab [NUM_TESTS] = '{READY_HIGH, READY_HIGH, READY_HIGH, READY_HIGH,
                                 READY_RANDOM, READY_HELD_LOW};
    int spike_tab [NUM_TESTS][MAX_SPIKES] = '{
        '{20, -1, -1, -1, -1, -1},
        '{10, 30, -1, -1, -1, -1},
        '{5, -1, -1, -1, -1, -1},
        '{10, 11, 12, 13, 15, 30},
        '{15, 40, 70, -1, -1, -1},
        '{20, 70, 120, 170, 220, -1}
    };

    logic AXIS_ACLK;
    logic AXIS_ARESETN;
    logic [S_DATA_WIDTH-1:0] s_tdata;
    logic s_tvalid;
    logic [M_DATA_WIDTH-1:0] m_tdata;
    logic m_tvalid;
    logic m_tready;
    logic m_tuser;
    logic m_tlast;
    logic cfg_wr;
    logic [1:0] cfg_addr;
    logic [15:0] cfg_wdata;
    logic [DROP_WIDTH-1:0] drop_count;
    logic fifo_full;

    // predicted output words in order
    logic [M_DATA_WIDTH-1:0] exp_data [$];
    bit exp_user [$];
    bit exp_last [$];
    int exp_drops;
    bit exp_full;
    string test_name;
    int word_idx;
    int cycle_count = 0;
    int cycle_limit = 0;
    logic [31:0] lcg_state;

    acq_top dut0 (
        .AXIS_ACLK(AXIS_ACLK),
        .AXIS_ARESETN(AXIS_ARESETN),
        .s_tdata(s_tdata),
        .s_tvalid(s_tvalid),
        .m_tdata(m_tdata),
        .m_tvalid(m_tvalid),
        .m_tready(m_tready),
        .m_tuser(m_tuser),
        .m_tlast(m_tlast),
        .cfg_wr(cfg_wr),
        .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata),
        .drop_count(drop_count),
        .fifo_full(fifo_full)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #20 AXIS_ACLK = ~AXIS_ACLK;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit is_spike(input int row, input int idx);
        bit hit;
        hit = 1'b0;
        for (int k = 0; k < MAX_SPIKES; k++)
        begin
            if (spike_tab[row][k] == idx)
                hit = 1'b1;
        end
        return hit;
    endfunction

    // background is the beat index in every lane and spikes sit in lane 3
    function automatic logic [S_DATA_WIDTH-1:0] beat_value(input int row, input int idx);
        logic [S_DATA_WIDTH-1:0] beat;
        beat = '0;
        if (idx >= 0)
        begin
            for (int l = 0; l < LANES; l++)
                beat[l*LANE_WIDTH +: LANE_WIDTH] = LANE_WIDTH'(idx % 1024);
            if (is_spike(row, idx))
                beat[3*LANE_WIDTH +: LANE_WIDTH] = 16'd4095;
        end
        return beat;
    endfunction

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %h, actual %h", what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic push_beat(input logic [S_DATA_WIDTH-1:0] beat, input bit first,
                             input bit last);
        exp_data.push_back(beat[M_DATA_WIDTH-1:0]);
        exp_user.push_back(first);
        exp_last.push_back(1'b0);
        exp_data.push_back(beat[S_DATA_WIDTH-1 -: M_DATA_WIDTH]);
        exp_user.push_back(1'b0);
        exp_last.push_back(last);
    endtask

    // frame and drop rules applied to the row's stream
    task automatic build_model(input int row);
        int pre;
        int post;
        int held;
        int written;
        int frame_no;
        int busy_until;
        bit over;
        bit prev_over;
        logic [S_DATA_WIDTH-1:0] hdr;
        exp_data.delete();
        exp_user.delete();
        exp_last.delete();
        exp_drops = 0;
        pre = (pre_tab[row] > int'(PRE_MAX)) ? int'(PRE_MAX) : pre_tab[row];
        post = (post_tab[row] < 1) ? 1 : post_tab[row];
        post = (post > int'(POST_MAX)) ? int'(POST_MAX) : post;
        written = 0;
        frame_no = 0;
        busy_until = -1;
        prev_over = 1'b0;
        for (int x = 0; x < len_tab[row]; x++)
        begin
            over = is_spike(row, x) || ((x % 1024) >= thr_tab[row]);
            if (over && !prev_over && x > busy_until)
            begin
                // downsizer keeps one beat outside the FIFO while stalled
                held = (written > 0) ? written - 1 : 0;
                if (int'(FIFO_DEPTH) - held >= 1 + pre + post)
                begin
                    hdr = '0;
                    hdr[31:0] = 32'(x);
                    hdr[47:32] = 16'(frame_no);
                    hdr[127:112] = HDR_MAGIC;
                    push_beat(hdr, 1'b1, 1'b0);
                    for (int b = x - pre; b < x + post; b++)
                        push_beat(beat_value(row, b), 1'b0, b == x + post - 1);
                    written += 1 + pre + post;
                    frame_no++;
                    busy_until = x + pre + post;
                end
                else
                begin
                    exp_drops++;
                end
            end
            prev_over = over;
        end
        // only a stalled DMA lets the FIFO fill up
        exp_full = (mode_tab[row] == READY_HELD_LOW) && (written - 1 >= int'(FIFO_DEPTH));
    endtask

    task automatic next_cycle();
        @(posedge AXIS_ACLK);
        #2;
    endtask

    task automatic set_ready(input int row, input bit in_stream);
        lcg_state = lcg_next(lcg_state);
        case (mode_tab[row])
            READY_RANDOM: m_tready = (lcg_state[17:16] != 2'b00);
            READY_HELD_LOW: m_tready = !in_stream;
            default: m_tready = 1'b1;
        endcase
    endtask

    task automatic write_reg(input logic [1:0] addr, input int value);
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = 16'(value);
        next_cycle();
        cfg_wr = 1'b0;
    endtask

    task automatic run_test(input int row);
        test_name = name_tab[row];
        word_idx = 0;
        build_model(row);
        AXIS_ARESETN = 1'b0;
        s_tvalid = 1'b0;
        s_tdata = '0;
        m_tready = 1'b1;
        cfg_wr = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        AXIS_ARESETN = 1'b1;
        if (cfg_tab[row])
        begin
            write_reg(REG_THRESHOLD, thr_tab[row]);
            write_reg(REG_PRE_LEN, pre_tab[row]);
            write_reg(REG_POST_LEN, post_tab[row]);
        end
        for (int x = 0; x < len_tab[row]; x++)
        begin
            s_tvalid = 1'b1;
            s_tdata = beat_value(row, x);
            set_ready(row, 1'b1);
            next_cycle();
        end
        s_tvalid = 1'b0;
        s_tdata = '0;
        check_value({test_name, " fifo_full"}, 128'(exp_full), 128'(fifo_full));
        while (exp_data.size() != 0)
        begin
            set_ready(row, 1'b0);
            next_cycle();
        end
        // quiet stretch to catch stray words
        m_tready = 1'b1;
        repeat (6) next_cycle();
        check_value({test_name, " drop_count"}, 128'(exp_drops), 128'(drop_count));
    endtask

    // sampled mid-cycle since transfers happen at the next rising edge
    always @(negedge AXIS_ACLK)
    begin
        if (dut0.chk0.fail_count != 0)
        begin
            $display("stream checker assertion failed during %s", test_name);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failure");
        end
        else if (AXIS_ARESETN && m_tvalid && m_tready)
        begin
            if (exp_data.size() == 0)
            begin
                $display("%s sent word %0d when no word was expected", test_name, word_idx);
                $display("Simulation finished: FAIL");
                $fatal(1, "unexpected output word");
            end
            else
            begin
                check_value($sformatf("%s word %0d tdata", test_name, word_idx),
                            128'(exp_data[0]), 128'(m_tdata));
                check_value($sformatf("%s word %0d tuser", test_name, word_idx),
                            128'(exp_user[0]), 128'(m_tuser));
                check_value($sformatf("%s word %0d tlast", test_name, word_idx),
                            128'(exp_last[0]), 128'(m_tlast));
                exp_data.delete(0);
                exp_user.delete(0);
                exp_last.delete(0);
                word_idx++;
            end
        end
    end

    always @(posedge AXIS_ACLK)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles during %s", cycle_count, test_name);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        int total_len;
        int total_words;
        AXIS_ARESETN = 1'b0;
        s_tdata = '0;
        s_tvalid = 1'b0;
        m_tready = 1'b1;
        cfg_wr = 1'b0;
        cfg_addr = 2'd0;
        cfg_wdata = 16'd0;
        lcg_state = LCG_SEED;
        test_name = "startup";
        total_len = 0;
        total_words = 0;
        // size the run before any clock edge
        for (int r = 0; r < NUM_TESTS; r++)
        begin
            build_model(r);
            total_len += len_tab[r] + ROW_OVERHEAD;
            total_words += exp_data.size();
        end
        cycle_limit = total_len + total_words * 4 + 500;
        for (int r = 0; r < NUM_TESTS; r++)
            run_test(r);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* Makefile */
VERILATOR ?= verilator
TOP ?= acq_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT = Simulation finished: PASS

SOURCES = $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
verilog/stream_pkg.sv
verilog/capture_pkg.sv
verilog/capture_regs.sv
verilog/level_trigger.sv
verilog/capture_ctrl.sv
verilog/sync_fifo.sv
verilog/width_downsizer.sv
verilog/acq_top.sv
tests/acq_chk.sv
tests/acq_tb.sv
